/* acc_pkg.sv */
`default_nettype none

package acc_pkg;

    localparam int ELEM_W = 16; // A and B element width
    localparam int ACC_W  = 32; // Accumulator and C element width
    localparam int STEP_W = 3;  // Loop count field width, room for N up to 8

    typedef enum logic [6:0] {
        R     = 7'b0110011, // ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
        I     = 7'b0010011, // ADDI SLTI SLTIU XORI ORI ANDI
        S     = 7'b0100011, // SB SH SW
        L     = 7'b0000011, // LB LH LW LBU LHU
        B     = 7'b1100011, // BEQ BNE BLT BGE BLTU BGEU
        LUI   = 7'b0110111,
        AUIPC = 7'b0010111,
        JAL   = 7'b1101111,
        JALR  = 7'b1100111,
        ACC   = 7'b0001011  // custom-0, matrix engine
    } rv_opcode_e;

    typedef enum logic [2:0] {
        LOAD   = 3'd0, // rs1 low half into A or B
        SAVE   = 3'd1, // C element out
        MATMUL = 3'd2, // C = A * B
        RESET  = 3'd3, // Clear A, B and C
        MOVE   = 3'd4  // A = trunc16(C)
    } acc_op_e;

    typedef enum logic [1:0] {
        FROM_ALU,
        FROM_MEM,
        FROM_PC
    } reg_src_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } acc_state_e;

    typedef struct packed {
        logic     branch;
        logic     jal;
        logic     jalr;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write_enable;
        reg_src_e reg_src;
        logic [2:0] funct3; // Branch, load and store type alike
    } core_ctrl_t;

    typedef struct packed {
        logic              valid;
        acc_op_e           op;
        logic [6:0]        index; // instr[31:25]
        logic [ELEM_W-1:0] data;  // rs1 low half
    } acc_cmd_t;

    typedef struct packed {
        logic [STEP_W-1:0] i;
        logic [STEP_W-1:0] j;
        logic [STEP_W-1:0] k;
        logic              first_k;
        logic              last_k;
        logic              last;  // Final step of the product
    } step_t;

endpackage

`default_nettype wire

/* control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  wire logic [31:0]        instr,
    input  wire logic               instr_valid,
    input  wire logic [31:0]        rs1_data,
    output acc_pkg::core_ctrl_t     core_ctrl,
    output acc_pkg::acc_cmd_t       raw_cmd
);

    acc_pkg::rv_opcode_e opcode;
    logic [2:0]          funct3;

    assign opcode = acc_pkg::rv_opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];

    always_comb begin
        core_ctrl = '0;                             // Plain ALU op as baseline
        core_ctrl.reg_src = acc_pkg::FROM_ALU;
        core_ctrl.funct3 = funct3;
        case (opcode)
            acc_pkg::R, acc_pkg::I, acc_pkg::LUI, acc_pkg::AUIPC: begin
                core_ctrl.reg_write_enable = 1'b1;  // Result from ALU
            end
            acc_pkg::S: begin
                core_ctrl.mem_write = 1'b1;
                core_ctrl.reg_src = acc_pkg::FROM_MEM;
            end
            acc_pkg::L: begin
                core_ctrl.mem_read = 1'b1;
                core_ctrl.reg_write_enable = 1'b1;
                core_ctrl.reg_src = acc_pkg::FROM_MEM;
            end
            acc_pkg::B: begin
                core_ctrl.branch = 1'b1;            // Compare type in funct3
            end
            acc_pkg::JAL: begin
                core_ctrl.jal = 1'b1;
                core_ctrl.reg_write_enable = 1'b1;  // Link address
                core_ctrl.reg_src = acc_pkg::FROM_PC;
            end
            acc_pkg::JALR: begin
                core_ctrl.jalr = 1'b1;
                core_ctrl.reg_write_enable = 1'b1;
                core_ctrl.reg_src = acc_pkg::FROM_PC;
            end
            acc_pkg::ACC: begin
                core_ctrl.reg_src = acc_pkg::FROM_MEM;
                core_ctrl.mem_read = (funct3 == acc_pkg::SAVE);         // C element back
                core_ctrl.reg_write_enable = (funct3 == acc_pkg::SAVE);
                core_ctrl.mem_write = (funct3 == acc_pkg::LOAD);        // Operand out
            end
            default: begin
                core_ctrl.funct3 = 3'd0;            // Unknown word reads as all zero
                core_ctrl.reg_src = acc_pkg::FROM_PC;
            end
        endcase
    end

    always_comb begin
        raw_cmd.index = instr[31:25];
        raw_cmd.data = rs1_data[acc_pkg::ELEM_W-1:0];
        raw_cmd.op = acc_pkg::acc_op_e'(funct3);
        raw_cmd.valid = instr_valid && (opcode == acc_pkg::ACC) && (funct3 <= 3'd4);
        if (funct3 > 3'd4) begin
            raw_cmd.op = acc_pkg::LOAD;              // Keep op a legal member
        end
    end

endmodule

`default_nettype wire

/* acc_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module acc_fsm (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire acc_pkg::acc_cmd_t  raw_cmd,
    input  wire logic               step_last,
    output acc_pkg::acc_cmd_t       issue_cmd,
    output logic                    count_en,
    output logic                    count_clear,
    output logic                    mac_en,
    output logic                    busy,
    output logic                    done
);

    acc_pkg::acc_state_e state;
    acc_pkg::acc_state_e state_nxt;
    logic                start;

    assign start = (state == acc_pkg::IDLE) && raw_cmd.valid && (raw_cmd.op == acc_pkg::MATMUL);

    always_comb begin
        state_nxt = state;
        case (state)
            acc_pkg::IDLE: begin
                if (start) begin
                    state_nxt = acc_pkg::RUN;
                end
            end
            acc_pkg::RUN: begin
                if (step_last && count_en) begin
                    state_nxt = acc_pkg::DONE;   // Last MAC lands this edge
                end
            end
            default: begin
                state_nxt = acc_pkg::IDLE;       // One cycle in DONE
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= acc_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Commands pass only while idle, dropped otherwise
    always_comb begin
        issue_cmd = raw_cmd;
        if (state != acc_pkg::IDLE) begin
            issue_cmd.valid = 1'b0;
        end
    end

    assign count_clear = start;                  // Counter at zero for first RUN cycle
    assign count_en = (state == acc_pkg::RUN);
    assign mac_en = (state == acc_pkg::RUN);
    assign busy = (state != acc_pkg::IDLE);
    assign done = (state == acc_pkg::DONE);

endmodule

`default_nettype wire

/* step_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module step_counter #(
    parameter int N = 2
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       clear,
    input  wire logic       en,
    output acc_pkg::step_t  step
);

    localparam int IDX_W = $clog2(N);
    localparam int SW = acc_pkg::STEP_W;
    localparam logic [IDX_W-1:0] MAX = IDX_W'(N - 1); // Wrap value

    logic [IDX_W-1:0] i_cnt;
    logic [IDX_W-1:0] j_cnt;
    logic [IDX_W-1:0] k_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            i_cnt <= '0;
            j_cnt <= '0;
            k_cnt <= '0;
        end else if (en) begin
            if (k_cnt == MAX) begin              // k innermost
                k_cnt <= '0;
                if (j_cnt == MAX) begin
                    j_cnt <= '0;
                    i_cnt <= (i_cnt == MAX) ? '0 : i_cnt + 1'b1;
                end else begin
                    j_cnt <= j_cnt + 1'b1;
                end
            end else begin
                k_cnt <= k_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        step.i = SW'(i_cnt);
        step.j = SW'(j_cnt);
        step.k = SW'(k_cnt);
        step.first_k = (k_cnt == '0);            // Accumulator restarts
        step.last_k = (k_cnt == MAX);            // C element complete
        step.last = (k_cnt == MAX) && (j_cnt == MAX) && (i_cnt == MAX);
    end

endmodule

`default_nettype wire

/* operand_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_buffer #(
    parameter int N = 2
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire acc_pkg::acc_cmd_t                 cmd,
    input  wire acc_pkg::step_t                    step,
    input  wire logic [N*N*acc_pkg::ACC_W-1:0]     c_flat,
    output logic signed [acc_pkg::ELEM_W-1:0]      a_elem,
    output logic signed [acc_pkg::ELEM_W-1:0]      b_elem
);

    localparam int IDX_W = $clog2(N);
    localparam int NN = N * N;
    localparam int AW = 2 * IDX_W;               // Row-major element address

    logic signed [acc_pkg::ELEM_W-1:0] a_mem [NN];
    logic signed [acc_pkg::ELEM_W-1:0] b_mem [NN];
    logic [AW-1:0] ld_addr;
    logic ld_a;
    logic ld_b;
    logic mv;
    logic clr;

    // NN is a power of two, so low bits give the B offset too
    assign ld_addr = cmd.index[AW-1:0];
    assign ld_a = cmd.valid && (cmd.op == acc_pkg::LOAD) && (int'(cmd.index) < NN);
    assign ld_b = cmd.valid && (cmd.op == acc_pkg::LOAD) && (int'(cmd.index) >= NN)
                  && (int'(cmd.index) < 2 * NN);
    assign mv = cmd.valid && (cmd.op == acc_pkg::MOVE);
    assign clr = cmd.valid && (cmd.op == acc_pkg::RESET);

    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            for (int e = 0; e < NN; e++) begin
                a_mem[e] <= '0;
                b_mem[e] <= '0;
            end
        end else begin
            if (mv) begin
                for (int e = 0; e < NN; e++) begin
                    a_mem[e] <= c_flat[e*acc_pkg::ACC_W +: acc_pkg::ELEM_W]; // Low half of C
                end
            end else if (ld_a) begin
                a_mem[ld_addr] <= cmd.data;
            end
            if (ld_b) begin
                b_mem[ld_addr] <= cmd.data;
            end
        end
    end

    assign a_elem = a_mem[{step.i[IDX_W-1:0], step.k[IDX_W-1:0]}]; // A[i][k]
    assign b_elem = b_mem[{step.k[IDX_W-1:0], step.j[IDX_W-1:0]}]; // B[k][j]

endmodule

`default_nettype wire

/* mac_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module mac_unit #(
    parameter int N = 2
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              en,
    input  wire acc_pkg::acc_cmd_t                 cmd,
    input  wire acc_pkg::step_t                    step,
    input  wire logic signed [acc_pkg::ELEM_W-1:0] a_elem,
    input  wire logic signed [acc_pkg::ELEM_W-1:0] b_elem,
    output logic [N*N*acc_pkg::ACC_W-1:0]          c_flat,
    output logic signed [acc_pkg::ACC_W-1:0]       save_data,
    output logic                                   save_valid
);

    localparam int IDX_W = $clog2(N);
    localparam int NN = N * N;
    localparam int AW = 2 * IDX_W;

    logic signed [acc_pkg::ACC_W-1:0] c_mem [NN];
    logic signed [acc_pkg::ACC_W-1:0] acc;
    logic signed [acc_pkg::ACC_W-1:0] prod;
    logic signed [acc_pkg::ACC_W-1:0] sum;
    logic [AW-1:0] wr_addr;
    logic clr;
    logic sv;

    assign prod = a_elem * b_elem;                       // Sign extended to 32 bits
    assign sum = step.first_k ? prod : acc + prod;       // Fresh sum on new element
    assign wr_addr = {step.i[IDX_W-1:0], step.j[IDX_W-1:0]}; // C[i][j]
    assign clr = cmd.valid && (cmd.op == acc_pkg::RESET);
    assign sv = cmd.valid && (cmd.op == acc_pkg::SAVE);

    always_ff @(posedge clk) begin
        if (en) begin
            acc <= sum;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            for (int e = 0; e < NN; e++) begin
                c_mem[e] <= '0;
            end
        end else if (en && step.last_k) begin
            c_mem[wr_addr] <= sum;                       // Includes current product
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            save_valid <= 1'b0;
        end else begin
            save_valid <= sv;                            // One cycle after strobe
        end
    end

    always_ff @(posedge clk) begin
        if (sv) begin
            save_data <= (int'(cmd.index) < NN) ? c_mem[cmd.index[AW-1:0]] : '0;
        end
    end

    always_comb begin
        for (int e = 0; e < NN; e++) begin
            c_flat[e*acc_pkg::ACC_W +: acc_pkg::ACC_W] = c_mem[e]; // Element 0 at LSB
        end
    end

endmodule

`default_nettype wire

/* acc_top.sv */
`timescale 1ns/1ns
`default_nettype none

module acc_top #(
    parameter int N = 2 // Power of two, 2*N*N <= 128
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic [31:0]                  instr,
    input  wire logic                         instr_valid,
    input  wire logic [31:0]                  rs1_data,
    output acc_pkg::core_ctrl_t               core_ctrl,
    output logic                              busy,
    output logic                              done,
    output logic signed [acc_pkg::ACC_W-1:0]  save_data,
    output logic                              save_valid
);

    acc_pkg::acc_cmd_t raw_cmd;                  // Decoded, before busy filter
    acc_pkg::acc_cmd_t issue_cmd;                // Accepted by the engine
    acc_pkg::step_t    step;
    logic count_en;
    logic count_clear;
    logic mac_en;
    logic signed [acc_pkg::ELEM_W-1:0] a_elem;
    logic signed [acc_pkg::ELEM_W-1:0] b_elem;
    logic [N*N*acc_pkg::ACC_W-1:0] c_flat;

    control_unit u_ctrl (
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs1_data    (rs1_data),
        .core_ctrl   (core_ctrl),
        .raw_cmd     (raw_cmd)
    );

    acc_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .raw_cmd     (raw_cmd),
        .step_last   (step.last),
        .issue_cmd   (issue_cmd),
        .count_en    (count_en),
        .count_clear (count_clear),
        .mac_en      (mac_en),
        .busy        (busy),
        .done        (done)
    );

    step_counter #(.N(N)) u_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (count_clear),
        .en    (count_en),
        .step  (step)
    );

    operand_buffer #(.N(N)) u_buf (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd    (issue_cmd),
        .step   (step),
        .c_flat (c_flat),
        .a_elem (a_elem),
        .b_elem (b_elem)
    );

    mac_unit #(.N(N)) u_mac (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (mac_en),
        .cmd        (issue_cmd),
        .step       (step),
        .a_elem     (a_elem),
        .b_elem     (b_elem),
        .c_flat     (c_flat),
        .save_data  (save_data),
        .save_valid (save_valid)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 10 // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk; // 50% duty

endmodule

`default_nettype wire

/* acc_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module acc_tb;

    localparam int N = 2;
    localparam int NN = N * N;
    localparam int RUN_LEN = N * N * N + 1;           // Busy cycles per MATMUL
    localparam int TIMEOUT = 200;                     // Cycles allowed for done

    typedef struct packed {
        logic [31:0]         instr;
        acc_pkg::core_ctrl_t ctrl;                    // Expected decode
    } dec_vec_t;

    typedef struct packed {
        acc_pkg::acc_op_e op;
        logic [6:0]       index;
        logic [15:0]      data;
        logic             drop;                       // Sent while busy and must vanish
    } acc_step_t;

    logic clk;
    logic rst_n;
    logic [31:0] instr;
    logic instr_valid;
    logic [31:0] rs1_data;
    acc_pkg::core_ctrl_t core_ctrl;
    logic busy;
    logic done;
    logic signed [31:0] save_data;
    logic save_valid;

    dec_vec_t  dec_tab[$];
    acc_step_t prog[$];
    int a_m[NN];                                      // Reference A sign extended
    int b_m[NN];
    int c_m[NN];
    logic exp_sv;                                     // save_valid due this cycle
    int exp_sd;
    logic mm_pending;
    int mm_cyc;                                       // Cycles since MATMUL strobe
    int error_count;

    tb_clock_gen clk_gen0 (.clk(clk));

    acc_top #(.N(N)) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs1_data    (rs1_data),
        .core_ctrl   (core_ctrl),
        .busy        (busy),
        .done        (done),
        .save_data   (save_data),
        .save_valid  (save_valid)
    );

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        error_count++;
        $display("error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
        $display("Done: errors found");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("failure at %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first failure");
    endtask

    function automatic acc_pkg::core_ctrl_t mk_ctrl(input logic br, input logic jal,
            input logic jalr, input logic mr, input logic mw, input logic rwe,
            input acc_pkg::reg_src_e src, input logic [2:0] f3);
        acc_pkg::core_ctrl_t c;
        c.branch = br;
        c.jal = jal;
        c.jalr = jalr;
        c.mem_read = mr;
        c.mem_write = mw;
        c.reg_write_enable = rwe;
        c.reg_src = src;
        c.funct3 = f3;
        return c;
    endfunction

    function automatic int sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic add_dec(input logic [31:0] word, input acc_pkg::core_ctrl_t ctrl);
        dec_vec_t v;
        v.instr = word;
        v.ctrl = ctrl;
        dec_tab.push_back(v);
    endtask

    task automatic add_step(input acc_pkg::acc_op_e op, input int index,
                            input logic [15:0] data, input logic drop);
        acc_step_t s;
        s.op = op;
        s.index = 7'(index);
        s.data = data;
        s.drop = drop;
        prog.push_back(s);
    endtask

    // One cycle with outputs checked at the falling edge
    task automatic tick();
        @(negedge clk);
        mm_cyc++;
        assert (save_valid == exp_sv) else
            report_mismatch("save_valid", 32'(exp_sv), 32'(save_valid));
        if (exp_sv) begin
            assert (save_data == exp_sd) else report_mismatch("save_data", exp_sd, save_data);
        end
        if (mm_pending) begin
            assert (busy) else report_problem("busy fell before done");
        end else begin
            assert (!busy) else report_problem("busy is high with no MATMUL running");
            assert (!done) else report_problem("done pulsed with no MATMUL running");
        end
        exp_sv = 1'b0;
    endtask

    task automatic model_apply(input acc_step_t s);
        int idx;
        int sum;
        idx = int'(s.index);
        case (s.op)
            acc_pkg::LOAD: begin
                if (idx < NN) begin
                    a_m[idx] = sext16(s.data);
                end else if (idx < 2 * NN) begin
                    b_m[idx - NN] = sext16(s.data);
                end
            end
            acc_pkg::MATMUL: begin
                for (int i = 0; i < N; i++) begin
                    for (int j = 0; j < N; j++) begin
                        sum = 0;
                        for (int k = 0; k < N; k++) begin
                            sum += a_m[i*N + k] * b_m[k*N + j]; // Wraps at 32 bits
                        end
                        c_m[i*N + j] = sum;
                    end
                end
            end
            acc_pkg::MOVE: begin
                for (int e = 0; e < NN; e++) begin
                    a_m[e] = sext16(c_m[e][15:0]);
                end
            end
            acc_pkg::RESET: begin
                for (int e = 0; e < NN; e++) begin
                    a_m[e] = 0;
                    b_m[e] = 0;
                    c_m[e] = 0;
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic wait_done();
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            tick();
            n++;
            seen = done;
        end
        if (!seen) begin
            report_problem("timeout, done never came after MATMUL");
        end
        assert (mm_cyc == RUN_LEN) else report_mismatch("busy length", RUN_LEN, mm_cyc);
        mm_pending = 1'b0;
        tick();                                       // Back to idle with busy low
    endtask

    task automatic issue_step(input acc_step_t s);
        int idx;
        idx = int'(s.index);
        if (mm_pending && !s.drop) begin
            wait_done();
        end
        if (s.drop) begin
            assert (busy) else report_problem("engine idle when a dropped command was sent");
        end else begin
            model_apply(s);
        end
        instr = {s.index, 10'd0, s.op, 5'd0, acc_pkg::ACC};
        instr_valid = 1'b1;
        rs1_data = {16'($urandom()), s.data};         // Upper half is ignored
        if (s.op == acc_pkg::MATMUL && !s.drop) begin
            mm_pending = 1'b1;
            mm_cyc = 0;
        end
        if (s.op == acc_pkg::SAVE && !s.drop) begin
            exp_sv = 1'b1;
            exp_sd = (idx < NN) ? c_m[idx] : 0;
        end
        tick();
        instr_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(13613));
        error_count = 0;
        exp_sv = 1'b0;
        exp_sd = 0;
        mm_pending = 1'b0;
        mm_cyc = 0;
        rst_n = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        rs1_data = '0;
        for (int e = 0; e < NN; e++) begin
            a_m[e] = 0;
            b_m[e] = 0;
            c_m[e] = 0;
        end

        // Decode vectors with funct3 in bits 14:12
        add_dec(32'h00000033, mk_ctrl(0, 0, 0, 0, 0, 1, acc_pkg::FROM_ALU, 3'd0)); // ADD
        add_dec(32'h00004013, mk_ctrl(0, 0, 0, 0, 0, 1, acc_pkg::FROM_ALU, 3'd4)); // XORI
        add_dec(32'h00002023, mk_ctrl(0, 0, 0, 0, 1, 0, acc_pkg::FROM_MEM, 3'd2)); // SW
        add_dec(32'h00002003, mk_ctrl(0, 0, 0, 1, 0, 1, acc_pkg::FROM_MEM, 3'd2)); // LW
        add_dec(32'h00001063, mk_ctrl(1, 0, 0, 0, 0, 0, acc_pkg::FROM_ALU, 3'd1)); // BNE
        add_dec(32'h00000037, mk_ctrl(0, 0, 0, 0, 0, 1, acc_pkg::FROM_ALU, 3'd0)); // LUI
        add_dec(32'h00000017, mk_ctrl(0, 0, 0, 0, 0, 1, acc_pkg::FROM_ALU, 3'd0)); // AUIPC
        add_dec(32'h0000006F, mk_ctrl(0, 1, 0, 0, 0, 1, acc_pkg::FROM_PC, 3'd0));  // JAL
        add_dec(32'h00000067, mk_ctrl(0, 0, 1, 0, 0, 1, acc_pkg::FROM_PC, 3'd0));  // JALR
        add_dec(32'h0000000B, mk_ctrl(0, 0, 0, 0, 1, 0, acc_pkg::FROM_MEM, 3'd0)); // ACC LOAD
        add_dec(32'h0000100B, mk_ctrl(0, 0, 0, 1, 0, 1, acc_pkg::FROM_MEM, 3'd1)); // ACC SAVE
        add_dec(32'h0000200B, mk_ctrl(0, 0, 0, 0, 0, 0, acc_pkg::FROM_MEM, 3'd2)); // MATMUL
        add_dec(32'h0000707F, mk_ctrl(0, 0, 0, 0, 0, 0, acc_pkg::FROM_PC, 3'd0));  // Unknown

        // Engine program covering multiply, busy drop, move and reset
        for (int e = 0; e < 2 * NN; e++) begin
            add_step(acc_pkg::LOAD, e, 16'($urandom()), 1'b0);
        end
        add_step(acc_pkg::MATMUL, 0, 16'h0, 1'b0);
        add_step(acc_pkg::LOAD, 0, 16'h7fff, 1'b1);
        add_step(acc_pkg::LOAD, NN + 1, 16'h8001, 1'b1);
        for (int e = 0; e < NN; e++) begin
            add_step(acc_pkg::SAVE, e, 16'h0, 1'b0);
        end
        add_step(acc_pkg::MATMUL, 0, 16'h0, 1'b0);    // Same C again
        for (int e = 0; e < NN; e++) begin
            add_step(acc_pkg::SAVE, e, 16'h0, 1'b0);
        end
        add_step(acc_pkg::MOVE, 0, 16'h0, 1'b0);
        add_step(acc_pkg::MATMUL, 0, 16'h0, 1'b0);
        for (int e = 0; e < NN; e++) begin
            add_step(acc_pkg::SAVE, e, 16'h0, 1'b0);
        end
        add_step(acc_pkg::RESET, 0, 16'h0, 1'b0);
        for (int e = 0; e < NN; e++) begin
            add_step(acc_pkg::SAVE, e, 16'h0, 1'b0);
        end
        add_step(acc_pkg::MATMUL, 0, 16'h0, 1'b0);
        for (int e = 0; e < NN; e++) begin
            add_step(acc_pkg::SAVE, e, 16'h0, 1'b0);
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (!busy) else report_mismatch("busy", 32'd0, 32'(busy));
        assert (!done) else report_mismatch("done", 32'd0, 32'(done));
        assert (!save_valid) else report_mismatch("save_valid", 32'd0, 32'(save_valid));
        tick();

        for (int d = 0; d < dec_tab.size(); d++) begin
            instr = dec_tab[d].instr;
            rs1_data = $urandom();
            tick();
            assert (core_ctrl == dec_tab[d].ctrl) else
                report_mismatch("core_ctrl", 32'(dec_tab[d].ctrl), 32'(core_ctrl));
        end

        for (int p = 0; p < prog.size(); p++) begin
            issue_step(prog[p]);
        end
        if (mm_pending) begin
            wait_done();
        end
        tick();

        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
acc_pkg.sv
control_unit.sv
acc_fsm.sv
step_counter.sv
operand_buffer.sv
mac_unit.sv
acc_top.sv
tb_clock_gen.sv
acc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the matrix engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module acc_tb -o acc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/acc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
